//--- sim.f
src/link_pkt_pkg.sv
src/host_regs_pkg.sv
src/payload_ram.sv
src/host_regs.sv
src/seq_fsm.sv
src/frame_timer.sv
src/frame_builder.sv
src/pkt_tx_top.sv
bench/pkt_tx_checker.sv
bench/tb_pkt_tx.sv

//--- run.sh
#!/usr/bin/env bash
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f sim.f --top-module tb_pkt_tx -o sim_tb
if [ $? -ne 0 ]; then
    echo "build failed"
    exit 1
fi

./obj_dir/sim_tb > sim.log 2>&1
status=$?
cat sim.log

if grep -q "tests failed" sim.log; then
    exit 1
fi
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi
exit 0

//--- bench/tb_pkt_tx.sv
`timescale 1ns/1ps

module tb_pkt_tx;

    localparam int RAM_AW = 8;
    localparam int RAM_SZ = 1 << RAM_AW;

    // Run settings
    localparam int LEN1 = 20;
    localparam int GAP1 = 3;
    localparam int LEN2 = 24;
    localparam int GAP2 = 5;
    localparam int RUN1_CYC = (21 + LEN1 + 4) + 7 * (GAP1 + 2);
    localparam int RUN2_CYC = (21 + LEN2 + 4) + 7 * (GAP2 + 2);
    localparam int AXI_CYC = 8 * (RAM_SZ + 40) + 100;
    localparam int LIMIT = 4 * (RUN1_CYC + RUN2_CYC) + AXI_CYC;

    typedef logic [7:0] byte_q_t[$];

    logic                      clk;
    logic                      rst;
    host_regs_pkg::axil_req_t  host_req;
    host_regs_pkg::axil_rsp_t  host_rsp;
    link_pkt_pkg::tx_beat_t    tx;
    logic                      tx_valid;
    logic                      tx_ready;

    integer                    seed;
    logic                      rand_ready;
    logic [7:0]                tb_mem [0:RAM_SZ-1];
    link_pkt_pkg::frame_cfg_t  exp_cfg;
    link_pkt_pkg::tx_beat_t    exp_q[$];
    int                        errors;
    int                        frame_cnt;
    int                        idle_cnt;
    logic                      after_last;
    int                        cyc;

    pkt_tx_top #(.RAM_AW(RAM_AW)) DUT (
        .clk      (clk),
        .rst      (rst),
        .host_req (host_req),
        .host_rsp (host_rsp),
        .tx       (tx),
        .tx_valid (tx_valid),
        .tx_ready (tx_ready)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    task automatic report_error(input string msg);
        errors++;
        $display("%s", msg);
        $display("tests failed");
        $fatal(1);
    endtask

    task automatic check_beat(input link_pkt_pkg::tx_beat_t got,
                              input link_pkt_pkg::tx_beat_t exp);
        if (got !== exp)
            report_error($sformatf("error at %0t: tx got %h/%b expected %h/%b",
                                   $time, got.data, got.last, exp.data, exp.last));
    endtask

    task automatic check_reg(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
        if (got !== exp)
            report_error($sformatf("error at %0t: %s got %h expected %h",
                                   $time, name, got, exp));
    endtask

    task automatic check_resp(input string name, input host_regs_pkg::resp_e got,
                              input host_regs_pkg::resp_e exp);
        if (got !== exp)
            report_error($sformatf("error at %0t: %s response got %s expected %s",
                                   $time, name, got.name(), exp.name()));
    endtask

    // Expected bytes of one frame, checksum last
    function automatic byte_q_t ref_frame(input link_pkt_pkg::btype_e t,
                                          input link_pkt_pkg::frame_cfg_t c);
        byte_q_t    q;
        logic [7:0] x;
        q.push_back(c.head);
        q.push_back({t, c.didx});
        case (t)
            link_pkt_pkg::DLINK: q.push_back(c.link_id);
            link_pkt_pkg::DTYPE: q.push_back(c.dev_type);
            link_pkt_pkg::DTEMP: q.push_back(c.temp);
            link_pkt_pkg::DATA0: begin
                q.push_back(c.data_len);
                for (int k = 0; k < c.data_len; k++)
                    q.push_back(tb_mem[(int'(c.ram_base) + k) % RAM_SZ]);
            end
            default: ;
        endcase
        x = 8'h00;
        foreach (q[i])
            x = x ^ q[i];
        q.push_back(x);
        return q;
    endfunction

    task automatic queue_run();
        link_pkt_pkg::btype_e order[7];
        byte_q_t              fr;
        order = '{link_pkt_pkg::ACK, link_pkt_pkg::NAK, link_pkt_pkg::STALL,
                  link_pkt_pkg::DLINK, link_pkt_pkg::DTYPE, link_pkt_pkg::DTEMP,
                  link_pkt_pkg::DATA0};
        foreach (order[f]) begin
            fr = ref_frame(order[f], exp_cfg);
            foreach (fr[i])
                exp_q.push_back('{data: fr[i], last: (i == fr.size() - 1)});
        end
    endtask

    task automatic axi_write(input logic [11:0] addr, input logic [31:0] data,
                             output host_regs_pkg::resp_e resp);
        @(posedge clk);
        host_req.awaddr  <= addr;
        host_req.wdata   <= data;
        host_req.wstrb   <= 4'hf;
        host_req.awvalid <= 1'b1;
        host_req.wvalid  <= 1'b1;
        host_req.bready  <= 1'b0; // bvalid has to hold a cycle
        @(negedge clk);
        while (!(host_rsp.awready && host_rsp.wready))
            @(negedge clk);
        @(posedge clk);
        host_req.awvalid <= 1'b0;
        host_req.wvalid  <= 1'b0;
        @(negedge clk);
        while (!host_rsp.bvalid)
            @(negedge clk);
        resp = host_rsp.bresp;
        @(posedge clk);
        host_req.bready <= 1'b1;
        @(negedge clk);
    endtask

    task automatic axi_read(input logic [11:0] addr, output logic [31:0] data,
                            output host_regs_pkg::resp_e resp);
        @(posedge clk);
        host_req.araddr  <= addr;
        host_req.arvalid <= 1'b1;
        host_req.rready  <= 1'b0; // rvalid has to hold a cycle
        @(negedge clk);
        while (!host_rsp.arready)
            @(negedge clk);
        @(posedge clk);
        host_req.arvalid <= 1'b0;
        @(negedge clk);
        while (!host_rsp.rvalid)
            @(negedge clk);
        data = host_rsp.rdata;
        resp = host_rsp.rresp;
        @(posedge clk);
        host_req.rready <= 1'b1;
        @(negedge clk);
    endtask

    task automatic write_ok(input string name, input logic [11:0] addr,
                            input logic [31:0] data);
        host_regs_pkg::resp_e r;
        axi_write(addr, data, r);
        check_resp(name, r, host_regs_pkg::OKAY);
    endtask

    task automatic read_check(input string name, input logic [11:0] addr,
                              input logic [31:0] exp);
        host_regs_pkg::resp_e r;
        logic [31:0]          d;
        axi_read(addr, d, r);
        check_resp(name, r, host_regs_pkg::OKAY);
        check_reg(name, d, exp);
    endtask

    task automatic setup_run(input logic [31:0] id, input logic [31:0] dev,
                             input logic [31:0] data, input logic [31:0] gap);
        write_ok("ID", host_regs_pkg::REG_ID, id);
        write_ok("DEV", host_regs_pkg::REG_DEV, dev);
        write_ok("DATA", host_regs_pkg::REG_DATA, data);
        write_ok("GAP", host_regs_pkg::REG_GAP, gap);
        read_check("ID", host_regs_pkg::REG_ID, id);
        read_check("DEV", host_regs_pkg::REG_DEV, dev);
        read_check("DATA", host_regs_pkg::REG_DATA, data);
        read_check("GAP", host_regs_pkg::REG_GAP, gap);
        exp_cfg = '{head: id[7:0], didx: id[11:8], link_id: id[23:16],
                    dev_type: dev[7:0], temp: dev[15:8], ram_base: data[7:0],
                    data_len: data[15:8], gap: gap[7:0]};
    endtask

    task automatic do_run(input logic rnd);
        host_regs_pkg::resp_e r;
        logic [31:0]          d;
        frame_cnt  = 0;
        after_last = 1'b0;
        rand_ready = rnd;
        queue_run();
        write_ok("CTRL", host_regs_pkg::REG_CTRL, 32'h1);
        read_check("STATUS during run", host_regs_pkg::REG_STATUS, 32'h1);
        write_ok("CTRL while busy", host_regs_pkg::REG_CTRL, 32'h1);
        d = '0;
        while (!d[1])
            axi_read(host_regs_pkg::REG_STATUS, d, r);
        repeat (10) @(posedge clk);
        read_check("STATUS after run", host_regs_pkg::REG_STATUS, 32'h2);
        check_reg("frame count", frame_cnt, 7);
        if (exp_q.size() != 0)
            report_error($sformatf("run ended with %0d expected beats never sent",
                                   exp_q.size()));
    endtask

    // Stream ready, random in the second run
    initial begin
        logic [31:0] r;
        tx_ready = 1'b0;
        forever begin
            @(posedge clk);
            r = $random(seed);
            tx_ready <= rand_ready ? r[0] : 1'b1;
        end
    end

    // Beats are taken at the negedge before the accepting edge
    initial begin
        forever begin
            @(negedge clk);
            if (!rst && tx_valid && tx_ready) begin
                if (after_last && idle_cnt < exp_cfg.gap)
                    report_error($sformatf("only %0d idle cycles between frames, gap is %0d",
                                           idle_cnt, exp_cfg.gap));
                after_last = 1'b0;
                if (exp_q.size() == 0)
                    report_error("a beat was sent when none was expected");
                check_beat(tx, exp_q.pop_front());
                if (tx.last) begin
                    frame_cnt++;
                    after_last = 1'b1;
                    idle_cnt   = 0;
                end
            end else if (!tx_valid) begin
                idle_cnt++;
            end
        end
    end

    initial begin
        cyc = 0;
        forever begin
            @(posedge clk);
            cyc++;
            if (cyc > LIMIT) begin
                $display("timeout after %0d cycles, the run did not finish", cyc);
                $display("tests failed");
                $fatal(1);
            end
        end
    end

    initial begin
        host_regs_pkg::resp_e r;
        logic [31:0]          d;
        seed       = 32'hab2e_83ac;
        rand_ready = 1'b0;
        errors     = 0;
        idle_cnt   = 0;
        after_last = 1'b0;
        exp_cfg    = '0;
        host_req   = '0;
        rst        = 1'b1;
        repeat (8) @(posedge clk);
        rst <= 1'b0;

        for (int i = 0; i < RAM_SZ; i++) begin
            d = $random(seed);
            tb_mem[i] = d[7:0];
            write_ok("RAM", host_regs_pkg::RAM_WIN + 12'(4 * i), {24'd0, d[7:0]});
        end

        // Error responses
        axi_write(host_regs_pkg::REG_STATUS, 32'h3, r);
        check_resp("STATUS write", r, host_regs_pkg::SLVERR);
        axi_write(12'h030, 32'h1, r);
        check_resp("unknown write", r, host_regs_pkg::SLVERR);
        axi_read(12'h020, d, r);
        check_resp("unknown read", r, host_regs_pkg::SLVERR);
        read_check("CTRL", host_regs_pkg::REG_CTRL, 32'h0);

        setup_run(32'h005a_07c3, 32'h0000_4d17, {16'd0, 8'(LEN1), 8'h10}, GAP1);
        do_run(1'b0);

        // Payload base near the top of the buffer
        setup_run(32'h003e_0b81, 32'h0000_90e2, {16'd0, 8'(LEN2), 8'hf6}, GAP2);
        do_run(1'b1);

        if (errors == 0)
            $display("all tests passed");
        else
            $display("tests failed");
        $finish;
    end

endmodule

//--- bench/pkt_tx_checker.sv
`timescale 1ns/1ps

module pkt_tx_checker (
    input logic                      clk,
    input logic                      rst,
    input link_pkt_pkg::tx_beat_t    tx,
    input logic                      tx_valid,
    input logic                      tx_ready,
    input logic                      busy,
    input logic                      done,
    input host_regs_pkg::axil_req_t  host_req,
    input host_regs_pkg::axil_rsp_t  host_rsp
);

    // Stream beat holds while stalled
    assert property (@(posedge clk) disable iff (rst)
        tx_valid && !tx_ready |=> tx_valid && $stable(tx))
        else $error("tx changed while stalled");

    assert property (@(posedge clk) disable iff (rst) tx_valid |-> busy)
        else $error("tx_valid outside a run");

    assert property (@(posedge clk) disable iff (rst)
        host_rsp.bvalid && !host_req.bready |=> host_rsp.bvalid)
        else $error("bvalid dropped before bready");

    assert property (@(posedge clk) disable iff (rst)
        host_rsp.rvalid && !host_req.rready |=> host_rsp.rvalid)
        else $error("rvalid dropped before rready");

    assert property (@(posedge clk) disable iff (rst) !(busy && done))
        else $error("busy and done both high");

endmodule

bind pkt_tx_top pkt_tx_checker u_checker (
    .clk      (clk),
    .rst      (rst),
    .tx       (tx),
    .tx_valid (tx_valid),
    .tx_ready (tx_ready),
    .busy     (busy),
    .done     (done),
    .host_req (host_req),
    .host_rsp (host_rsp)
);

//--- src/pkt_tx_top.sv
`timescale 1ns/1ps

module pkt_tx_top #(
    parameter int RAM_AW = 8
) (
    input  logic                      clk,
    input  logic                      rst,
    input  host_regs_pkg::axil_req_t  host_req,
    output host_regs_pkg::axil_rsp_t  host_rsp,
    output link_pkt_pkg::tx_beat_t    tx,
    output logic                      tx_valid,
    input  logic                      tx_ready
);

    link_pkt_pkg::frame_cfg_t cfg;
    link_pkt_pkg::btype_e     btype;
    logic                     start;
    logic                     busy;
    logic                     done;
    logic                     wr_en;
    logic [RAM_AW-1:0]        wr_addr;
    logic [7:0]               wr_data;
    logic [RAM_AW-1:0]        rd_addr;
    logic [7:0]               rd_data;
    logic                     frame_go;
    logic                     gap_go;
    logic                     gap_done;
    logic                     beat_fire;
    logic                     frame_done;
    logic [7:0]               idx;

    host_regs #(.RAM_AW(RAM_AW)) u_regs (
        .clk      (clk),
        .rst      (rst),
        .host_req (host_req),
        .host_rsp (host_rsp),
        .cfg      (cfg),
        .start    (start),
        .busy     (busy),
        .done     (done),
        .wr_en    (wr_en),
        .wr_addr  (wr_addr),
        .wr_data  (wr_data)
    );

    seq_fsm u_seq (
        .clk        (clk),
        .rst        (rst),
        .start      (start),
        .frame_done (frame_done),
        .gap_done   (gap_done),
        .btype      (btype),
        .frame_go   (frame_go),
        .gap_go     (gap_go),
        .busy       (busy),
        .done       (done)
    );

    frame_timer u_timer (
        .clk       (clk),
        .rst       (rst),
        .frame_go  (frame_go),
        .beat_fire (beat_fire),
        .gap_go    (gap_go),
        .gap       (cfg.gap),
        .idx       (idx),
        .gap_done  (gap_done)
    );

    frame_builder #(.RAM_AW(RAM_AW)) u_build (
        .clk        (clk),
        .rst        (rst),
        .cfg        (cfg),
        .btype      (btype),
        .frame_go   (frame_go),
        .idx        (idx),
        .tx         (tx),
        .tx_valid   (tx_valid),
        .tx_ready   (tx_ready),
        .beat_fire  (beat_fire),
        .frame_done (frame_done),
        .rd_addr    (rd_addr),
        .rd_data    (rd_data)
    );

    payload_ram #(.RAM_AW(RAM_AW)) u_ram (
        .clk     (clk),
        .wr_en   (wr_en),
        .wr_addr (wr_addr),
        .wr_data (wr_data),
        .rd_addr (rd_addr),
        .rd_data (rd_data)
    );

endmodule

//--- src/frame_builder.sv
`timescale 1ns/1ps

module frame_builder #(
    parameter int RAM_AW = 8
) (
    input  logic                      clk,
    input  logic                      rst,
    input  link_pkt_pkg::frame_cfg_t  cfg,
    input  link_pkt_pkg::btype_e      btype,
    input  logic                      frame_go,
    input  logic [7:0]                idx,
    output link_pkt_pkg::tx_beat_t    tx,
    output logic                      tx_valid,
    input  logic                      tx_ready,
    output logic                      beat_fire,
    output logic                      frame_done,
    output logic [RAM_AW-1:0]         rd_addr,
    input  logic [7:0]                rd_data
);

    logic       active;
    logic       rd_pend;  // Buffer read in flight
    logic       in_pay;   // Past the length byte of DATA0
    logic       has_body;
    logic       is_chk;
    logic       is_pay;
    logic       load;
    logic [7:0] chk;
    logic [7:0] pay_cnt;
    logic [7:0] hdr_last;
    logic [7:0] sel_byte;

    assign has_body = btype inside {link_pkt_pkg::DLINK, link_pkt_pkg::DTYPE,
                                    link_pkt_pkg::DTEMP};
    assign hdr_last = has_body ? 8'd3 : 8'd2;
    assign pay_cnt  = idx - 8'd3;
    assign is_chk   = (btype == link_pkt_pkg::DATA0) ? (in_pay && pay_cnt == cfg.data_len)
                                                     : (idx == hdr_last);
    assign is_pay   = in_pay && !is_chk;
    assign load     = active && !tx_valid && !rd_pend;

    assign rd_addr    = RAM_AW'(cfg.ram_base) + RAM_AW'(pay_cnt); // Wraps in buffer
    assign beat_fire  = tx_valid && tx_ready;
    assign frame_done = beat_fire && tx.last;

    always_comb begin
        sel_byte = 8'h00;
        if (is_chk) begin
            sel_byte = chk;
        end else begin
            case (idx)
                8'd1: sel_byte = {btype, cfg.didx};
                8'd2: begin
                    case (btype)
                        link_pkt_pkg::DLINK: sel_byte = cfg.link_id;
                        link_pkt_pkg::DTYPE: sel_byte = cfg.dev_type;
                        link_pkt_pkg::DTEMP: sel_byte = cfg.temp;
                        link_pkt_pkg::DATA0: sel_byte = cfg.data_len;
                        default:             sel_byte = 8'h00;
                    endcase
                end
                default: sel_byte = 8'h00;
            endcase
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            active   <= 1'b0;
            tx_valid <= 1'b0;
            rd_pend  <= 1'b0;
            in_pay   <= 1'b0;
            chk      <= '0;
        end else if (frame_go) begin
            active   <= 1'b1;
            tx_valid <= 1'b1; // Header goes out right away
            rd_pend  <= 1'b0;
            in_pay   <= 1'b0;
            chk      <= '0;
        end else begin
            if (beat_fire) begin
                tx_valid <= 1'b0;
                chk      <= chk ^ tx.data;
                if (tx.last)
                    active <= 1'b0;
                if (btype == link_pkt_pkg::DATA0 && idx == 8'd2 && !in_pay)
                    in_pay <= 1'b1;
            end
            if (rd_pend) begin
                rd_pend  <= 1'b0;
                tx_valid <= 1'b1;
            end else if (load) begin
                if (is_pay)
                    rd_pend <= 1'b1;
                else
                    tx_valid <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (frame_go) begin
            tx.data <= cfg.head;
            tx.last <= 1'b0;
        end else if (rd_pend) begin
            tx.data <= rd_data;
            tx.last <= 1'b0;
        end else if (load && !is_pay) begin
            tx.data <= sel_byte;
            tx.last <= is_chk;
        end
    end

endmodule

//--- src/frame_timer.sv
`timescale 1ns/1ps

module frame_timer (
    input  logic       clk,
    input  logic       rst,
    input  logic       frame_go,
    input  logic       beat_fire,
    input  logic       gap_go,
    input  logic [7:0] gap,
    output logic [7:0] idx,
    output logic       gap_done
);

    logic [7:0] gap_cnt;
    logic       gap_run;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            idx     <= '0;
            gap_cnt <= '0;
            gap_run <= 1'b0;
        end else begin
            if (frame_go)
                idx <= '0;
            else if (beat_fire)
                idx <= idx + 8'd1; // Wraps on long DATA0 frames

            if (gap_go) begin
                gap_cnt <= gap;
                gap_run <= 1'b1;
            end else if (gap_run) begin
                if (gap_cnt == 8'd0)
                    gap_run <= 1'b0;
                else
                    gap_cnt <= gap_cnt - 8'd1;
            end
        end
    end

    // gap+1 cycles after gap_go
    assign gap_done = gap_run && (gap_cnt == 8'd0);

endmodule

//--- src/seq_fsm.sv
`timescale 1ns/1ps

module seq_fsm (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  start,
    input  logic                  frame_done,
    input  logic                  gap_done,
    output link_pkt_pkg::btype_e  btype,
    output logic                  frame_go,
    output logic                  gap_go,
    output logic                  busy,
    output logic                  done
);

    typedef enum logic [1:0] {
        IDLE,
        LOAD,
        SEND,
        GAP
    } state_e;

    state_e state;
    state_e state_nx;
    logic   last_frame;

    // Fixed order of one run
    function automatic link_pkt_pkg::btype_e next_type(input link_pkt_pkg::btype_e cur);
        case (cur)
            link_pkt_pkg::ACK:   return link_pkt_pkg::NAK;
            link_pkt_pkg::NAK:   return link_pkt_pkg::STALL;
            link_pkt_pkg::STALL: return link_pkt_pkg::DLINK;
            link_pkt_pkg::DLINK: return link_pkt_pkg::DTYPE;
            link_pkt_pkg::DTYPE: return link_pkt_pkg::DTEMP;
            default:             return link_pkt_pkg::DATA0;
        endcase
    endfunction

    assign last_frame = (btype == link_pkt_pkg::DATA0);

    always_comb begin
        state_nx = state;
        case (state)
            IDLE:    if (start) state_nx = LOAD;
            LOAD:    state_nx = SEND;
            SEND:    if (frame_done) state_nx = last_frame ? IDLE : GAP;
            GAP:     if (gap_done) state_nx = LOAD;
            default: state_nx = IDLE;
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state <= IDLE;
            btype <= link_pkt_pkg::INIT;
            done  <= 1'b0;
        end else begin
            state <= state_nx;
            if (state == IDLE && start) begin
                btype <= link_pkt_pkg::ACK;
                done  <= 1'b0;
            end else if (state == GAP && gap_done) begin
                btype <= next_type(btype);
            end
            if (state == SEND && frame_done && last_frame)
                done <= 1'b1; // No gap after DATA0
        end
    end

    assign frame_go = (state == LOAD);
    assign gap_go   = (state == SEND) && frame_done && !last_frame;
    assign busy     = (state != IDLE);

endmodule

//--- src/host_regs.sv
`timescale 1ns/1ps

module host_regs #(
    parameter int RAM_AW = 8
) (
    input  logic                      clk,
    input  logic                      rst,
    input  host_regs_pkg::axil_req_t  host_req,
    output host_regs_pkg::axil_rsp_t  host_rsp,
    output link_pkt_pkg::frame_cfg_t  cfg,
    output logic                      start,
    input  logic                      busy,
    input  logic                      done,
    output logic                      wr_en,
    output logic [RAM_AW-1:0]         wr_addr,
    output logic [7:0]                wr_data
);

    logic                 wr_acc;
    logic                 rd_acc;
    logic                 wr_ok;
    logic                 rd_ok;
    logic                 ram_hit;
    logic [11:0]          ram_off;
    logic [31:0]          rd_word;
    logic                 bvalid;
    logic                 rvalid;
    logic [31:0]          rdata;
    host_regs_pkg::resp_e bresp;
    host_regs_pkg::resp_e rresp;

    assign wr_acc  = host_req.awvalid && host_req.wvalid && !bvalid;
    assign rd_acc  = host_req.arvalid && !rvalid;
    assign ram_off = host_req.awaddr - host_regs_pkg::RAM_WIN;
    assign ram_hit = (host_req.awaddr >= host_regs_pkg::RAM_WIN) &&
                     ({22'd0, ram_off[11:2]} < (32'd1 << RAM_AW));

    assign start   = wr_acc && (host_req.awaddr == host_regs_pkg::REG_CTRL) &&
                     host_req.wstrb[0] && host_req.wdata[0] && !busy;
    assign wr_en   = wr_acc && ram_hit && host_req.wstrb[0];
    assign wr_addr = ram_off[RAM_AW+1:2];
    assign wr_data = host_req.wdata[7:0];

    always_comb begin
        case (host_req.awaddr)
            host_regs_pkg::REG_CTRL, host_regs_pkg::REG_ID, host_regs_pkg::REG_DEV,
            host_regs_pkg::REG_DATA, host_regs_pkg::REG_GAP: wr_ok = 1'b1;
            default: wr_ok = ram_hit; // STATUS lands here too
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            cfg <= '0;
        end else if (wr_acc) begin
            case (host_req.awaddr)
                host_regs_pkg::REG_ID: begin
                    if (host_req.wstrb[0]) cfg.head <= host_req.wdata[7:0];
                    if (host_req.wstrb[1]) cfg.didx <= host_req.wdata[11:8];
                    if (host_req.wstrb[2]) cfg.link_id <= host_req.wdata[23:16];
                end
                host_regs_pkg::REG_DEV: begin
                    if (host_req.wstrb[0]) cfg.dev_type <= host_req.wdata[7:0];
                    if (host_req.wstrb[1]) cfg.temp <= host_req.wdata[15:8];
                end
                host_regs_pkg::REG_DATA: begin
                    if (host_req.wstrb[0]) cfg.ram_base <= host_req.wdata[7:0];
                    if (host_req.wstrb[1]) cfg.data_len <= host_req.wdata[15:8];
                end
                host_regs_pkg::REG_GAP: begin
                    if (host_req.wstrb[0]) cfg.gap <= host_req.wdata[7:0];
                end
                default: ;
            endcase
        end
    end

    always_comb begin
        rd_ok   = 1'b1;
        rd_word = '0;
        case (host_req.araddr)
            host_regs_pkg::REG_CTRL:   rd_word = '0;
            host_regs_pkg::REG_STATUS: rd_word = {30'd0, done, busy};
            host_regs_pkg::REG_ID:     rd_word = {8'd0, cfg.link_id, 4'd0, cfg.didx, cfg.head};
            host_regs_pkg::REG_DEV:    rd_word = {16'd0, cfg.temp, cfg.dev_type};
            host_regs_pkg::REG_DATA:   rd_word = {16'd0, cfg.data_len, cfg.ram_base};
            host_regs_pkg::REG_GAP:    rd_word = {24'd0, cfg.gap};
            default:                   rd_ok = 1'b0; // Buffer is write only
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            bvalid <= 1'b0;
            bresp  <= host_regs_pkg::OKAY;
        end else if (wr_acc) begin
            bvalid <= 1'b1;
            bresp  <= wr_ok ? host_regs_pkg::OKAY : host_regs_pkg::SLVERR;
        end else if (host_req.bready) begin
            bvalid <= 1'b0;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            rvalid <= 1'b0;
            rresp  <= host_regs_pkg::OKAY;
            rdata  <= '0;
        end else if (rd_acc) begin
            rvalid <= 1'b1;
            rresp  <= rd_ok ? host_regs_pkg::OKAY : host_regs_pkg::SLVERR;
            rdata  <= rd_word;
        end else if (host_req.rready) begin
            rvalid <= 1'b0;
        end
    end

    always_comb begin
        host_rsp.awready = wr_acc;
        host_rsp.wready  = wr_acc;
        host_rsp.bresp   = bresp;
        host_rsp.bvalid  = bvalid;
        host_rsp.arready = !rvalid;
        host_rsp.rdata   = rdata;
        host_rsp.rresp   = rresp;
        host_rsp.rvalid  = rvalid;
    end

endmodule

//--- src/payload_ram.sv
`timescale 1ns/1ps

module payload_ram #(
    parameter int RAM_AW = 8
) (
    input  logic              clk,
    input  logic              wr_en,
    input  logic [RAM_AW-1:0] wr_addr,
    input  logic [7:0]        wr_data,
    input  logic [RAM_AW-1:0] rd_addr,
    output logic [7:0]        rd_data
);

    logic [7:0] mem [0:(1<<RAM_AW)-1];

    always_ff @(posedge clk) begin
        if (wr_en)
            mem[wr_addr] <= wr_data;
    end

    // Registered read, data one cycle after the address
    always_ff @(posedge clk) begin
        rd_data <= mem[rd_addr];
    end

endmodule

//--- src/host_regs_pkg.sv
package host_regs_pkg;

    typedef enum logic [1:0] {
        OKAY   = 2'b00,
        SLVERR = 2'b10
    } resp_e;

    // Manager to subordinate
    typedef struct packed {
        logic [11:0] awaddr;
        logic        awvalid;
        logic [31:0] wdata;
        logic [3:0]  wstrb;
        logic        wvalid;
        logic        bready;
        logic [11:0] araddr;
        logic        arvalid;
        logic        rready;
    } axil_req_t;

    // Subordinate to manager
    typedef struct packed {
        logic        awready;
        logic        wready;
        resp_e       bresp;
        logic        bvalid;
        logic        arready;
        logic [31:0] rdata;
        resp_e       rresp;
        logic        rvalid;
    } axil_rsp_t;

    localparam logic [11:0] REG_CTRL   = 12'h000; // Bit 0 starts a run
    localparam logic [11:0] REG_STATUS = 12'h004; // Busy, done
    localparam logic [11:0] REG_ID     = 12'h008;
    localparam logic [11:0] REG_DEV    = 12'h00c;
    localparam logic [11:0] REG_DATA   = 12'h010;
    localparam logic [11:0] REG_GAP    = 12'h014;
    localparam logic [11:0] RAM_WIN    = 12'h400; // One buffer byte per word

endpackage

//--- src/link_pkt_pkg.sv
package link_pkt_pkg;

    // Frame type codes carried in byte 1 bits 7:4
    typedef enum logic [3:0] {
        INIT  = 4'h0,
        ACK   = 4'h1,
        NAK   = 4'h2,
        STALL = 4'h3,
        DLINK = 4'h8,
        DTYPE = 4'h9,
        DTEMP = 4'ha,
        DATA0 = 4'hd
    } btype_e;

    // Run configuration as set up by the host
    typedef struct packed {
        logic [7:0] head;     // Header byte of every frame
        logic [3:0] didx;     // Device index
        logic [7:0] link_id;
        logic [7:0] dev_type;
        logic [7:0] temp;
        logic [7:0] ram_base; // First payload index
        logic [7:0] data_len; // Payload bytes in DATA0
        logic [7:0] gap;      // Idle cycles between frames
    } frame_cfg_t;

    // One byte on the outgoing stream
    typedef struct packed {
        logic [7:0] data;
        logic       last; // Checksum byte, end of frame
    } tx_beat_t;

endpackage
